/* flist.f */
src/bus_pkg.sv
src/bus_xbar.sv
src/clint_timer.sv
src/axi_sram.sv
src/mem_subsystem.sv
dv/mem_subsystem_assert.sv
dv/tb_mem_subsystem.sv

/* dv/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

	localparam logic [31:0] clint_base  = 32'h0200_0000;
	localparam logic [31:0] clint_limit = 32'h0200_ffff;
	localparam int sram_words  = 1024;
	localparam int n_fill      = 64;
	localparam int n_strobe    = 40;
	localparam int n_readback  = 32;
	localparam int n_prio      = 10;
	localparam int n_timer     = 12;
	localparam int n_bp        = 10;
	localparam int n_mixed     = 300;
	localparam int total_ops   = n_fill + n_strobe + 2 * n_readback + 2 * n_prio + n_timer +
		3 * n_bp + n_mixed;
	localparam int cycle_limit = total_ops * 20;

	logic                        clock;
	logic                        reset;
	logic [bus_pkg::addr_w-1:0]  fetch_araddr;
	logic                        fetch_arvalid;
	logic                        fetch_arready;
	logic [bus_pkg::data_w-1:0]  fetch_rdata;
	logic [bus_pkg::resp_w-1:0]  fetch_rresp;
	logic                        fetch_rvalid;
	logic                        fetch_rready;
	logic [bus_pkg::addr_w-1:0]  lsu_araddr;
	logic [bus_pkg::size_w-1:0]  lsu_arsize;
	logic                        lsu_arvalid;
	logic                        lsu_arready;
	logic [bus_pkg::data_w-1:0]  lsu_rdata;
	logic [bus_pkg::resp_w-1:0]  lsu_rresp;
	logic                        lsu_rvalid;
	logic                        lsu_rready;
	logic [bus_pkg::addr_w-1:0]  lsu_awaddr;
	logic [bus_pkg::size_w-1:0]  lsu_awsize;
	logic                        lsu_awvalid;
	logic                        lsu_awready;
	logic [bus_pkg::data_w-1:0]  lsu_wdata;
	logic [bus_pkg::strb_w-1:0]  lsu_wstrb;
	logic                        lsu_wvalid;
	logic                        lsu_wready;
	logic [bus_pkg::resp_w-1:0]  lsu_bresp;
	logic                        lsu_bvalid;
	logic                        lsu_bready;

	logic [bus_pkg::data_w-1:0]  mem_model [sram_words];
	logic [63:0]                 mtime_model;
	logic [31:0]                 rand_state;
	int                          error_count;
	int                          check_count;
	int                          cycle_count;
	time                         fetch_ar_t;
	time                         lsu_ar_t;

	mem_subsystem i_mem_subsystem (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		if (reset) begin
			mtime_model <= '0;
		end else begin
			mtime_model <= mtime_model + 1; // one tick per clock after reset release.
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Verification failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state ^ (rand_state >> 16); // fold the better high bits down.
	endfunction

	// upper nibble aliases onto the same sram word.
	function automatic logic [31:0] sram_addr(input logic [31:0] r);
		return {r[31:28], 20'h00000, r[5:0], 2'b00};
	endfunction

	function automatic logic [31:0] timer_addr(input logic [31:0] r);
		case (r[1:0])
			2'd0:    return clint_base;
			2'd1:    return clint_base + 32'd4;
			default: return clint_base + {16'h0000, r[15:2], 2'b00};
		endcase
	endfunction

	function automatic logic [31:0] expected_read(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - clint_base;
		if (addr >= clint_base && addr <= clint_limit) begin
			if (offset == 32'd0) begin
				return mtime_model[31:0];
			end else if (offset == 32'd4) begin
				return mtime_model[63:32];
			end
			return 32'h0;
		end
		return mem_model[(addr >> 2) % sram_words];
	endfunction

	task automatic check(input logic [63:0] expected, input logic [63:0] actual,
		input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at time %0t: %s, expected %h, got %h", $time, msg, expected,
				actual);
		end
	endtask

	// one read on either port with rready held low for hold cycles.
	task automatic read_port(input bit use_fetch, input logic [31:0] addr, input int hold,
		output time ar_t);
		logic [31:0] exp;
		string       port;
		port = use_fetch ? "fetch" : "lsu";
		if (use_fetch) begin
			fetch_araddr  = addr;
			fetch_arvalid = 1'b1;
			fetch_rready  = 1'b0;
		end else begin
			lsu_araddr  = addr;
			lsu_arvalid = 1'b1;
			lsu_rready  = 1'b0;
		end
		@(negedge clock);
		while (!(use_fetch ? fetch_arready : lsu_arready)) @(negedge clock);
		ar_t = $time;
		exp = expected_read(addr); // timer value seen at the address transfer.
		if (use_fetch) begin
			check(bus_pkg::fetch_size, i_mem_subsystem.soc_arsize, "fetch arsize");
		end
		@(posedge clock);
		#1;
		if (use_fetch) begin
			fetch_arvalid = 1'b0;
		end else begin
			lsu_arvalid = 1'b0;
		end
		repeat (hold) begin
			@(negedge clock);
			check(1, use_fetch ? fetch_rvalid : lsu_rvalid, {port, " rvalid held"});
			check(exp, use_fetch ? fetch_rdata : lsu_rdata, {port, " rdata held"});
			check(bus_pkg::resp_okay, use_fetch ? fetch_rresp : lsu_rresp, {port, " rresp held"});
			check(0, fetch_arready | lsu_arready, "second read granted during back-pressure");
			@(posedge clock);
			#1;
		end
		if (use_fetch) begin
			fetch_rready = 1'b1;
		end else begin
			lsu_rready = 1'b1;
		end
		@(negedge clock);
		while (!(use_fetch ? fetch_rvalid : lsu_rvalid)) @(negedge clock);
		check(exp, use_fetch ? fetch_rdata : lsu_rdata, {port, " rdata"});
		check(bus_pkg::resp_okay, use_fetch ? fetch_rresp : lsu_rresp, {port, " rresp"});
		@(posedge clock);
		#1;
		fetch_rready = use_fetch ? 1'b0 : fetch_rready;
		lsu_rready   = use_fetch ? lsu_rready : 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold);
		lsu_awaddr  = addr;
		lsu_awsize  = 3'd2;
		lsu_wdata   = data;
		lsu_wstrb   = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		lsu_bready  = 1'b0;
		@(negedge clock);
		while (!(lsu_awready && lsu_wready)) @(negedge clock);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				mem_model[(addr >> 2) % sram_words][8*b +: 8] = data[8*b +: 8];
			end
		end
		@(posedge clock);
		#1;
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		repeat (hold) begin
			@(negedge clock);
			check(1, lsu_bvalid, "bvalid held");
			check(bus_pkg::resp_okay, lsu_bresp, "bresp held");
			@(posedge clock);
			#1;
		end
		lsu_bready = 1'b1;
		@(negedge clock);
		while (!lsu_bvalid) @(negedge clock);
		check(bus_pkg::resp_okay, lsu_bresp, "bresp");
		@(posedge clock);
		#1;
		lsu_bready = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] fa;
		logic [31:0] la;
		int          assert_fails;
		reset         = 1'b1;
		fetch_araddr  = '0;
		fetch_arvalid = 1'b0;
		fetch_rready  = 1'b0;
		lsu_araddr    = '0;
		lsu_arsize    = 3'd2;
		lsu_arvalid   = 1'b0;
		lsu_rready    = 1'b0;
		lsu_awaddr    = '0;
		lsu_awsize    = 3'd2;
		lsu_awvalid   = 1'b0;
		lsu_wdata     = '0;
		lsu_wstrb     = '0;
		lsu_wvalid    = 1'b0;
		lsu_bready    = 1'b0;
		rand_state    = 32'd84;
		error_count   = 0;
		check_count   = 0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		// fill the test words and merge random strobes on top.
		for (int i = 0; i < n_fill; i++) begin
			r = next_rand();
			w = next_rand();
			write_word({r[31:28], 20'h00000, 6'(i), 2'b00}, w, 4'hf, 0);
		end
		for (int i = 0; i < n_strobe; i++) begin
			r = next_rand();
			w = next_rand();
			write_word(sram_addr(r), w, r[11:8], 0);
		end
		for (int i = 0; i < n_readback; i++) begin
			la = sram_addr(next_rand());
			read_port(0, la, 0, lsu_ar_t);
			read_port(1, {~la[31:28], la[27:0]}, 0, fetch_ar_t);
		end

		// both ports ask on the same cycle from idle.
		for (int i = 0; i < n_prio; i++) begin
			r = next_rand();
			fa = sram_addr(next_rand());
			la = r[6] ? timer_addr(next_rand()) : sram_addr(next_rand());
			fork
				read_port(1, fa, 0, fetch_ar_t);
				read_port(0, la, 0, lsu_ar_t);
			join
			check(1, fetch_ar_t < lsu_ar_t, "fetch address accepted before load-store");
		end

		for (int i = 0; i < n_timer; i++) begin
			read_port(0, timer_addr(next_rand()), 0, lsu_ar_t);
		end

		for (int i = 0; i < n_bp; i++) begin
			r = next_rand();
			fa = sram_addr(next_rand());
			la = sram_addr(next_rand());
			fork
				read_port(1, fa, 1 + r[10:8], fetch_ar_t);
				read_port(0, la, 1 + r[14:12], lsu_ar_t);
			join
			la = sram_addr(next_rand());
			w = next_rand();
			write_word(la, w, r[23:20], 1 + r[18:16]);
		end

		for (int i = 0; i < n_mixed; i++) begin
			r = next_rand();
			fa = sram_addr(next_rand());
			la = sram_addr(next_rand());
			w = next_rand();
			if (fa[7:2] == la[7:2]) begin
				fa[2] = ~fa[2]; // keep a concurrent fetch off the word being written.
			end
			case (r[1:0])
				2'd0: read_port(1, fa, r[4:3], fetch_ar_t);
				2'd1: fork
					if (r[2]) read_port(1, fa, r[4:3], fetch_ar_t);
					read_port(0, la, r[6:5], lsu_ar_t);
				join
				2'd2: fork
					if (r[2]) read_port(1, fa, r[4:3], fetch_ar_t);
					write_word(la, w, r[11:8], r[6:5]);
				join
				default: fork
					if (r[2]) read_port(1, fa, r[4:3], fetch_ar_t);
					read_port(0, timer_addr(w), r[6:5], lsu_ar_t);
				join
			endcase
		end

		assert_fails = i_mem_subsystem.i_bus_xbar.i_mem_subsystem_assert.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
			assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* dv/mem_subsystem_assert.sv */
`timescale 1ns/1ps

module mem_subsystem_assert (
	input logic                       clock,
	input logic                       reset,
	input logic                       fetch_reading,
	input logic                       lsu_reading,
	input logic                       fetch_arready,
	input logic [bus_pkg::data_w-1:0] fetch_rdata,
	input logic                       fetch_rvalid,
	input logic                       fetch_rready,
	input logic [bus_pkg::data_w-1:0] lsu_rdata,
	input logic                       lsu_rvalid,
	input logic                       lsu_rready
);

	int fail_count = 0;

	a_owner_one_hot: assert property (@(posedge clock) disable iff (reset)
		!(fetch_reading && lsu_reading))
		else begin
			fail_count++;
			$error("both read owner bits are set");
		end

	a_fetch_r_hold: assert property (@(posedge clock) disable iff (reset)
		(fetch_rvalid && !fetch_rready) |=> (fetch_rvalid && $stable(fetch_rdata)))
		else begin
			fail_count++;
			$error("fetch read response changed before rready");
		end

	a_lsu_r_hold: assert property (@(posedge clock) disable iff (reset)
		(lsu_rvalid && !lsu_rready) |=> (lsu_rvalid && $stable(lsu_rdata)))
		else begin
			fail_count++;
			$error("load-store read response changed before rready");
		end

	a_no_fetch_grant: assert property (@(posedge clock) disable iff (reset)
		!(fetch_arready && lsu_reading))
		else begin
			fail_count++;
			$error("fetch address accepted while load-store owns the read path");
		end

endmodule

bind bus_xbar mem_subsystem_assert i_mem_subsystem_assert (
	.clock         (clock),
	.reset         (reset),
	.fetch_reading (fetch_reading),
	.lsu_reading   (lsu_reading),
	.fetch_arready (fetch_arready),
	.fetch_rdata   (fetch_rdata),
	.fetch_rvalid  (fetch_rvalid),
	.fetch_rready  (fetch_rready),
	.lsu_rdata     (lsu_rdata),
	.lsu_rvalid    (lsu_rvalid),
	.lsu_rready    (lsu_rready)
);

/* src/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
	parameter logic [bus_pkg::addr_w-1:0] clint_base  = 32'h0200_0000,
	parameter logic [bus_pkg::addr_w-1:0] clint_limit = 32'h0200_ffff,
	parameter int                         sram_words  = 1024
) (
	input  logic                        clock,
	input  logic                        reset,

	input  logic [bus_pkg::addr_w-1:0]  fetch_araddr,
	input  logic                        fetch_arvalid,
	output logic                        fetch_arready,
	output logic [bus_pkg::data_w-1:0]  fetch_rdata,
	output logic [bus_pkg::resp_w-1:0]  fetch_rresp,
	output logic                        fetch_rvalid,
	input  logic                        fetch_rready,

	input  logic [bus_pkg::addr_w-1:0]  lsu_araddr,
	input  logic [bus_pkg::size_w-1:0]  lsu_arsize,
	input  logic                        lsu_arvalid,
	output logic                        lsu_arready,
	output logic [bus_pkg::data_w-1:0]  lsu_rdata,
	output logic [bus_pkg::resp_w-1:0]  lsu_rresp,
	output logic                        lsu_rvalid,
	input  logic                        lsu_rready,

	input  logic [bus_pkg::addr_w-1:0]  lsu_awaddr,
	input  logic [bus_pkg::size_w-1:0]  lsu_awsize,
	input  logic                        lsu_awvalid,
	output logic                        lsu_awready,
	input  logic [bus_pkg::data_w-1:0]  lsu_wdata,
	input  logic [bus_pkg::strb_w-1:0]  lsu_wstrb,
	input  logic                        lsu_wvalid,
	output logic                        lsu_wready,
	output logic [bus_pkg::resp_w-1:0]  lsu_bresp,
	output logic                        lsu_bvalid,
	input  logic                        lsu_bready
);

	// system bus side.
	logic [bus_pkg::addr_w-1:0] soc_araddr;
	logic [bus_pkg::size_w-1:0] soc_arsize;
	logic                       soc_arvalid;
	logic                       soc_arready;
	logic [bus_pkg::data_w-1:0] soc_rdata;
	logic [bus_pkg::resp_w-1:0] soc_rresp;
	logic                       soc_rvalid;
	logic                       soc_rready;
	logic [bus_pkg::addr_w-1:0] soc_awaddr;
	logic [bus_pkg::size_w-1:0] soc_awsize;
	logic                       soc_awvalid;
	logic                       soc_awready;
	logic [bus_pkg::data_w-1:0] soc_wdata;
	logic [bus_pkg::strb_w-1:0] soc_wstrb;
	logic                       soc_wvalid;
	logic                       soc_wready;
	logic [bus_pkg::resp_w-1:0] soc_bresp;
	logic                       soc_bvalid;
	logic                       soc_bready;

	// timer side.
	logic [bus_pkg::addr_w-1:0] clint_araddr;
	logic                       clint_arvalid;
	logic                       clint_arready;
	logic [bus_pkg::data_w-1:0] clint_rdata;
	logic                       clint_rvalid;
	logic                       clint_rready;

	bus_xbar #(
		.clint_base  (clint_base),
		.clint_limit (clint_limit)
	) i_bus_xbar (
		.clock         (clock),
		.reset         (reset),
		.fetch_araddr  (fetch_araddr),
		.fetch_arvalid (fetch_arvalid),
		.fetch_arready (fetch_arready),
		.fetch_rdata   (fetch_rdata),
		.fetch_rresp   (fetch_rresp),
		.fetch_rvalid  (fetch_rvalid),
		.fetch_rready  (fetch_rready),
		.lsu_araddr    (lsu_araddr),
		.lsu_arsize    (lsu_arsize),
		.lsu_arvalid   (lsu_arvalid),
		.lsu_arready   (lsu_arready),
		.lsu_rdata     (lsu_rdata),
		.lsu_rresp     (lsu_rresp),
		.lsu_rvalid    (lsu_rvalid),
		.lsu_rready    (lsu_rready),
		.lsu_awaddr    (lsu_awaddr),
		.lsu_awsize    (lsu_awsize),
		.lsu_awvalid   (lsu_awvalid),
		.lsu_awready   (lsu_awready),
		.lsu_wdata     (lsu_wdata),
		.lsu_wstrb     (lsu_wstrb),
		.lsu_wvalid    (lsu_wvalid),
		.lsu_wready    (lsu_wready),
		.lsu_bresp     (lsu_bresp),
		.lsu_bvalid    (lsu_bvalid),
		.lsu_bready    (lsu_bready),
		.soc_araddr    (soc_araddr),
		.soc_arsize    (soc_arsize),
		.soc_arvalid   (soc_arvalid),
		.soc_arready   (soc_arready),
		.soc_rdata     (soc_rdata),
		.soc_rresp     (soc_rresp),
		.soc_rvalid    (soc_rvalid),
		.soc_rready    (soc_rready),
		.soc_awaddr    (soc_awaddr),
		.soc_awsize    (soc_awsize),
		.soc_awvalid   (soc_awvalid),
		.soc_awready   (soc_awready),
		.soc_wdata     (soc_wdata),
		.soc_wstrb     (soc_wstrb),
		.soc_wvalid    (soc_wvalid),
		.soc_wready    (soc_wready),
		.soc_bresp     (soc_bresp),
		.soc_bvalid    (soc_bvalid),
		.soc_bready    (soc_bready),
		.clint_araddr  (clint_araddr),
		.clint_arvalid (clint_arvalid),
		.clint_arready (clint_arready),
		.clint_rdata   (clint_rdata),
		.clint_rvalid  (clint_rvalid),
		.clint_rready  (clint_rready)
	);

	clint_timer #(
		.clint_base (clint_base)
	) i_clint_timer (
		.clock         (clock),
		.reset         (reset),
		.clint_araddr  (clint_araddr),
		.clint_arvalid (clint_arvalid),
		.clint_arready (clint_arready),
		.clint_rdata   (clint_rdata),
		.clint_rvalid  (clint_rvalid),
		.clint_rready  (clint_rready)
	);

	axi_sram #(
		.sram_words (sram_words)
	) i_axi_sram (
		.clock       (clock),
		.reset       (reset),
		.soc_araddr  (soc_araddr),
		.soc_arsize  (soc_arsize),
		.soc_arvalid (soc_arvalid),
		.soc_arready (soc_arready),
		.soc_rdata   (soc_rdata),
		.soc_rresp   (soc_rresp),
		.soc_rvalid  (soc_rvalid),
		.soc_rready  (soc_rready),
		.soc_awaddr  (soc_awaddr),
		.soc_awsize  (soc_awsize),
		.soc_awvalid (soc_awvalid),
		.soc_awready (soc_awready),
		.soc_wdata   (soc_wdata),
		.soc_wstrb   (soc_wstrb),
		.soc_wvalid  (soc_wvalid),
		.soc_wready  (soc_wready),
		.soc_bresp   (soc_bresp),
		.soc_bvalid  (soc_bvalid),
		.soc_bready  (soc_bready)
	);

endmodule

/* src/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram #(
	parameter int sram_words = 1024
) (
	input  logic                        clock,
	input  logic                        reset,

	input  logic [bus_pkg::addr_w-1:0]  soc_araddr,
	input  logic [bus_pkg::size_w-1:0]  soc_arsize,
	input  logic                        soc_arvalid,
	output logic                        soc_arready,
	output logic [bus_pkg::data_w-1:0]  soc_rdata,
	output logic [bus_pkg::resp_w-1:0]  soc_rresp,
	output logic                        soc_rvalid,
	input  logic                        soc_rready,

	input  logic [bus_pkg::addr_w-1:0]  soc_awaddr,
	input  logic [bus_pkg::size_w-1:0]  soc_awsize,
	input  logic                        soc_awvalid,
	output logic                        soc_awready,
	input  logic [bus_pkg::data_w-1:0]  soc_wdata,
	input  logic [bus_pkg::strb_w-1:0]  soc_wstrb,
	input  logic                        soc_wvalid,
	output logic                        soc_wready,
	output logic [bus_pkg::resp_w-1:0]  soc_bresp,
	output logic                        soc_bvalid,
	input  logic                        soc_bready
);

	localparam int idx_w = (sram_words > 1) ? $clog2(sram_words) : 1;

	logic [bus_pkg::data_w-1:0] mem [sram_words];
	logic [idx_w-1:0]           rd_idx;
	logic [idx_w-1:0]           wr_idx;
	logic [bus_pkg::strb_w-1:0] rd_lanes;
	logic [bus_pkg::strb_w-1:0] wr_lanes;
	logic                       rd_busy;
	logic                       wr_busy;
	logic                       rd_fire;
	logic                       wr_fire;

	// byte lanes covered by a transfer of the given size.
	function automatic logic [bus_pkg::strb_w-1:0] size_lanes(
		input logic [bus_pkg::size_w-1:0] size,
		input logic [1:0]                 offset
	);
		case (size)
			3'd0:    size_lanes = 4'b0001 << offset;
			3'd1:    size_lanes = 4'b0011 << {offset[1], 1'b0};
			default: size_lanes = 4'b1111;
		endcase
	endfunction

	assign rd_idx   = idx_w'((soc_araddr >> 2) % sram_words); // wraps past the top.
	assign wr_idx   = idx_w'((soc_awaddr >> 2) % sram_words);
	assign rd_lanes = size_lanes(soc_arsize, soc_araddr[1:0]);
	assign wr_lanes = soc_wstrb & size_lanes(soc_awsize, soc_awaddr[1:0]);

	assign soc_arready = !rd_busy;
	assign rd_fire     = soc_arvalid & soc_arready;

	// address and data are taken together.
	assign soc_awready = soc_awvalid & soc_wvalid & !wr_busy;
	assign soc_wready  = soc_awready;
	assign wr_fire     = soc_awready;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_busy <= 1'b0;
			wr_busy <= 1'b0;
		end else begin
			if (rd_fire) begin
				rd_busy <= 1'b1;
			end else if (soc_rvalid && soc_rready) begin
				rd_busy <= 1'b0;
			end
			if (wr_fire) begin
				wr_busy <= 1'b1;
			end else if (soc_bvalid && soc_bready) begin
				wr_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_fire) begin
			for (int b = 0; b < bus_pkg::strb_w; b++) begin
				soc_rdata[8*b +: 8] <= rd_lanes[b] ? mem[rd_idx][8*b +: 8] : 8'h00;
			end
		end
		if (wr_fire) begin
			for (int b = 0; b < bus_pkg::strb_w; b++) begin
				if (wr_lanes[b]) begin
					mem[wr_idx][8*b +: 8] <= soc_wdata[8*b +: 8];
				end
			end
		end
	end

	assign soc_rvalid = rd_busy;
	assign soc_rresp  = bus_pkg::resp_okay;
	assign soc_bvalid = wr_busy;
	assign soc_bresp  = bus_pkg::resp_okay;

endmodule

/* src/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
	parameter logic [bus_pkg::addr_w-1:0] clint_base = 32'h0200_0000
) (
	input  logic                        clock,
	input  logic                        reset,

	input  logic [bus_pkg::addr_w-1:0]  clint_araddr,
	input  logic                        clint_arvalid,
	output logic                        clint_arready,

	output logic [bus_pkg::data_w-1:0]  clint_rdata,
	output logic                        clint_rvalid,
	input  logic                        clint_rready
);

	logic [2*bus_pkg::data_w-1:0] mtime;
	logic [bus_pkg::addr_w-1:0]   offset;
	logic [bus_pkg::data_w-1:0]   sel_word;
	logic                         busy;
	logic                         ar_fire;

	assign offset  = clint_araddr - clint_base;
	assign ar_fire = clint_arvalid & clint_arready;

	always_comb begin
		case (offset)
			32'h0000_0000: sel_word = mtime[bus_pkg::data_w-1:0];
			32'h0000_0004: sel_word = mtime[2*bus_pkg::data_w-1:bus_pkg::data_w];
			default:       sel_word = '0; // unmapped words in the window.
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1'b1; // free running.
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (ar_fire) begin
			busy <= 1'b1;
		end else if (clint_rvalid && clint_rready) begin
			busy <= 1'b0;
		end
	end

	// snapshot taken at the address handshake.
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			clint_rdata <= sel_word;
		end
	end

	assign clint_arready = !busy;
	assign clint_rvalid  = busy;

endmodule

/* src/bus_xbar.sv */
`timescale 1ns/1ps

module bus_xbar #(
	parameter logic [bus_pkg::addr_w-1:0] clint_base  = 32'h0200_0000,
	parameter logic [bus_pkg::addr_w-1:0] clint_limit = 32'h0200_ffff
) (
	input  logic                        clock,
	input  logic                        reset,

	input  logic [bus_pkg::addr_w-1:0]  fetch_araddr,
	input  logic                        fetch_arvalid,
	output logic                        fetch_arready,
	output logic [bus_pkg::data_w-1:0]  fetch_rdata,
	output logic [bus_pkg::resp_w-1:0]  fetch_rresp,
	output logic                        fetch_rvalid,
	input  logic                        fetch_rready,

	input  logic [bus_pkg::addr_w-1:0]  lsu_araddr,
	input  logic [bus_pkg::size_w-1:0]  lsu_arsize,
	input  logic                        lsu_arvalid,
	output logic                        lsu_arready,
	output logic [bus_pkg::data_w-1:0]  lsu_rdata,
	output logic [bus_pkg::resp_w-1:0]  lsu_rresp,
	output logic                        lsu_rvalid,
	input  logic                        lsu_rready,

	input  logic [bus_pkg::addr_w-1:0]  lsu_awaddr,
	input  logic [bus_pkg::size_w-1:0]  lsu_awsize,
	input  logic                        lsu_awvalid,
	output logic                        lsu_awready,
	input  logic [bus_pkg::data_w-1:0]  lsu_wdata,
	input  logic [bus_pkg::strb_w-1:0]  lsu_wstrb,
	input  logic                        lsu_wvalid,
	output logic                        lsu_wready,
	output logic [bus_pkg::resp_w-1:0]  lsu_bresp,
	output logic                        lsu_bvalid,
	input  logic                        lsu_bready,

	output logic [bus_pkg::addr_w-1:0]  soc_araddr,
	output logic [bus_pkg::size_w-1:0]  soc_arsize,
	output logic                        soc_arvalid,
	input  logic                        soc_arready,
	input  logic [bus_pkg::data_w-1:0]  soc_rdata,
	input  logic [bus_pkg::resp_w-1:0]  soc_rresp,
	input  logic                        soc_rvalid,
	output logic                        soc_rready,

	output logic [bus_pkg::addr_w-1:0]  soc_awaddr,
	output logic [bus_pkg::size_w-1:0]  soc_awsize,
	output logic                        soc_awvalid,
	input  logic                        soc_awready,
	output logic [bus_pkg::data_w-1:0]  soc_wdata,
	output logic [bus_pkg::strb_w-1:0]  soc_wstrb,
	output logic                        soc_wvalid,
	input  logic                        soc_wready,
	input  logic [bus_pkg::resp_w-1:0]  soc_bresp,
	input  logic                        soc_bvalid,
	output logic                        soc_bready,

	output logic [bus_pkg::addr_w-1:0]  clint_araddr,
	output logic                        clint_arvalid,
	input  logic                        clint_arready,
	input  logic [bus_pkg::data_w-1:0]  clint_rdata,
	input  logic                        clint_rvalid,
	output logic                        clint_rready
);

	logic fetch_reading;
	logic lsu_reading;
	logic ar_done;       // owner's address already accepted.
	logic lsu_in_clint;  // live decode for the address phase.
	logic lsu_clint_sel; // decode held for the data phase.
	logic fetch_done;
	logic lsu_done;
	logic ar_fire;

	assign lsu_in_clint = (lsu_araddr >= clint_base) && (lsu_araddr <= clint_limit);
	assign fetch_done   = fetch_rvalid & fetch_rready;
	assign lsu_done     = lsu_rvalid & lsu_rready;
	assign ar_fire      = (fetch_arvalid & fetch_arready) | (lsu_arvalid & lsu_arready);

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_reading <= 1'b0;
			lsu_reading   <= 1'b0;
		end else if (!fetch_reading && !lsu_reading) begin
			fetch_reading <= fetch_arvalid; // fetch wins a tie.
			lsu_reading   <= !fetch_arvalid && lsu_arvalid;
		end else begin
			fetch_reading <= fetch_reading && !fetch_done;
			lsu_reading   <= lsu_reading && !lsu_done;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_done       <= 1'b0;
			lsu_clint_sel <= 1'b0;
		end else begin
			if (fetch_done || lsu_done) begin
				ar_done <= 1'b0;
			end else if (ar_fire) begin
				ar_done <= 1'b1;
			end
			if (lsu_arvalid && lsu_arready) begin
				lsu_clint_sel <= lsu_in_clint;
			end
		end
	end

	// only one read outstanding in the address phase.
	assign soc_arvalid   = !ar_done & ((fetch_reading & fetch_arvalid) |
		(lsu_reading & !lsu_in_clint & lsu_arvalid));
	assign soc_araddr    = fetch_reading ? fetch_araddr :
		(lsu_reading && !lsu_in_clint) ? lsu_araddr : '0;
	assign soc_arsize    = fetch_reading ? bus_pkg::fetch_size :
		lsu_reading ? lsu_arsize : '0;
	assign clint_arvalid = !ar_done & lsu_reading & lsu_in_clint & lsu_arvalid;
	assign clint_araddr  = (lsu_reading && lsu_in_clint) ? lsu_araddr : '0;
	assign fetch_arready = fetch_reading & !ar_done & soc_arready;
	assign lsu_arready   = lsu_reading & !ar_done & (lsu_in_clint ? clint_arready : soc_arready);

	// data phase steered by the held decode.
	assign soc_rready    = (fetch_reading & fetch_rready) |
		(lsu_reading & !lsu_clint_sel & lsu_rready);
	assign clint_rready  = lsu_reading & lsu_clint_sel & lsu_rready;
	assign fetch_rvalid  = fetch_reading & ar_done & soc_rvalid;
	assign fetch_rdata   = fetch_reading ? soc_rdata : '0;
	assign fetch_rresp   = fetch_reading ? soc_rresp : '0;
	assign lsu_rvalid    = lsu_reading & ar_done & (lsu_clint_sel ? clint_rvalid : soc_rvalid);
	assign lsu_rdata     = !lsu_reading ? '0 : lsu_clint_sel ? clint_rdata : soc_rdata;
	assign lsu_rresp     = !lsu_reading ? '0 : lsu_clint_sel ? bus_pkg::resp_okay : soc_rresp;

	// writes always go to the system bus.
	assign soc_awaddr  = lsu_awaddr;
	assign soc_awsize  = lsu_awsize;
	assign soc_awvalid = lsu_awvalid;
	assign lsu_awready = soc_awready;
	assign soc_wdata   = lsu_wdata;
	assign soc_wstrb   = lsu_wstrb;
	assign soc_wvalid  = lsu_wvalid;
	assign lsu_wready  = soc_wready;
	assign lsu_bresp   = soc_bresp;
	assign lsu_bvalid  = soc_bvalid;
	assign soc_bready  = lsu_bready;

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

	// address and data path widths.
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8; // one strobe per byte lane.

	// response channel.
	localparam int resp_w = 2;
	localparam logic [resp_w-1:0] resp_okay = 2'b00;

	// transfer size field holds log2 of the byte count.
	localparam int size_w = 3;
	localparam logic [size_w-1:0] fetch_size = 3'b010; // instruction fetch is always 4 bytes.

endpackage
